//--- logic/sandInput_macros.svh
// Sand game input front end constants
// Screen geometry, cursor limits, queue depth and PS/2 prefixes
`ifndef SANDINPUT_MACROS_SVH
`define SANDINPUT_MACROS_SVH

// Visible screen in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// Cursor position after reset
`define CURSOR_HOME_X 320
`define CURSOR_HOME_Y 240

// Largest cursor size
`define CURSOR_SIZE_MAX 15

// Key events buffered between decoder and controller
`define EVENT_QUEUE_DEPTH 4

// PS/2 set-2 prefix bytes
`define PREFIX_BREAK 8'hF0
`define PREFIX_EXTENDED 8'hE0

`endif

//--- logic/sandInput_pkg.sv
// Sand game input front end types
// Particle types, set-2 scan codes and the decoded key event
`default_nettype none

package sandInput_pkg;

    // Particle types selectable as the cursor color
    typedef enum logic [3:0] {
        ptBlank    = 4'd0,
        ptFire     = 4'd1,
        ptTorch    = 4'd2,
        ptWater    = 4'd3,
        ptSand     = 4'd4,
        ptOil      = 4'd5,
        ptSalt     = 4'd6,
        ptConcrete = 4'd7,
        ptWall     = 4'd8,
        ptPlant    = 4'd9,
        ptWax      = 4'd10,
        ptSpout    = 4'd11
    } particle_t;

    // Set-2 make codes used by the game
    // Arrows share keypad codes and need the extended flag
    typedef enum logic [7:0] {
        scEscape = 8'h76,
        sc1      = 8'h16,
        sc2      = 8'h1E,
        sc3      = 8'h26,
        sc4      = 8'h25,
        scMinus  = 8'h4E,
        scEquals = 8'h55,
        scT      = 8'h2C,
        scP      = 8'h4D,
        scA      = 8'h1C,
        scS      = 8'h1B,
        scD      = 8'h23,
        scF      = 8'h2B,
        scG      = 8'h34,
        scH      = 8'h33,
        scZ      = 8'h1A,
        scX      = 8'h22,
        scC      = 8'h21,
        scV      = 8'h2A,
        scB      = 8'h32,
        scN      = 8'h31,
        scSpace  = 8'h29,
        scLeft   = 8'h6B,
        scRight  = 8'h74,
        scUp     = 8'h75,
        scDown   = 8'h72
    } scanCode_t;

    // One key action after prefix folding
    typedef struct packed {
        logic       extended;
        logic       released;
        logic [7:0] code;
    } keyEvent_t;

endpackage

`default_nettype wire

//--- logic/keyEventIf.sv
// Key event channel
// Valid/ready handshake carrying one decoded key event
`default_nettype none

interface keyEventIf;

    logic                     valid;
    logic                     ready;
    // Named keyEvent since event is a reserved word
    sandInput_pkg::keyEvent_t keyEvent;

    // Source side drives valid and payload
    modport producer (output valid, output keyEvent, input ready);

    // Sink side drives ready
    modport consumer (input valid, input keyEvent, output ready);

endinterface

`default_nettype wire

//--- logic/ps2EventDecoder.sv
// PS/2 scan byte decoder
// Folds F0 and E0 prefixes into a single key event per key action
`default_nettype none
`include "sandInput_macros.svh"

module ps2EventDecoder (
    input  wire         iCLK,
    input  wire         iRESET,
    input  wire         scanValid,
    input  wire  [7:0]  scanByte,
    output logic        scanReady,
    keyEventIf.producer out
);

    logic breakSeen;
    logic extendedSeen;
    logic takeByte;
    logic isBreak;
    logic isExtended;

    // Output register free when empty or draining this cycle
    assign scanReady = !out.valid || out.ready;
    assign takeByte = scanValid && scanReady;

    assign isBreak = (scanByte == `PREFIX_BREAK);
    assign isExtended = (scanByte == `PREFIX_EXTENDED);

    // Prefix flags and output valid
    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            out.valid <= 1'b0;
            breakSeen <= 1'b0;
            extendedSeen <= 1'b0;
        end else begin
            // Consumed event leaves the register
            if (out.ready) begin
                out.valid <= 1'b0;
            end
            if (takeByte) begin
                if (isBreak) begin
                    breakSeen <= 1'b1;
                end else if (isExtended) begin
                    extendedSeen <= 1'b1;
                end else begin
                    // Final byte closes the sequence
                    out.valid <= 1'b1;
                    breakSeen <= 1'b0;
                    extendedSeen <= 1'b0;
                end
            end
        end
    end

    // Event payload, loaded with the final byte
    always_ff @(posedge iCLK) begin
        if (takeByte && !isBreak && !isExtended) begin
            out.keyEvent <= '{
                extended: extendedSeen,
                released: breakSeen,
                code:     scanByte
            };
        end
    end

endmodule

`default_nettype wire

//--- logic/eventQueue.sv
// Synchronous FIFO for handshake payloads
// Head entry sits in an output register, rest in a circular buffer
`default_nettype none

module eventQueue #(
    parameter type payload_t = sandInput_pkg::keyEvent_t,
    parameter int  DEPTH     = 4
) (
    input  wire         iCLK,
    input  wire         iRESET,
    keyEventIf.consumer in,
    keyEventIf.producer out
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    payload_t         headData;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             doWrite;
    logic             slotOpen;
    logic             bypass;
    logic             doRead;
    logic             toMem;

    assign in.ready = (count != CNT_W'(DEPTH));
    assign doWrite = in.valid && in.ready;

    // Output register can take a new head
    assign slotOpen = !out.valid || out.ready;
    // Empty buffer, incoming word goes straight to the head
    assign bypass = doWrite && slotOpen && (count == '0);
    assign doRead = slotOpen && (count != '0);
    assign toMem = doWrite && !bypass;

    assign out.keyEvent = headData;

    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            out.valid <= 1'b0;
        end else begin
            if (toMem) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CNT_W'(toMem) - CNT_W'(doRead);
            if (slotOpen) begin
                out.valid <= doRead || bypass;
            end
        end
    end

    // Storage and head data
    always_ff @(posedge iCLK) begin
        if (toMem) begin
            mem[wrPtr] <= in.keyEvent;
        end
        if (doRead) begin
            headData <= mem[rdPtr];
        end else if (bypass) begin
            headData <= in.keyEvent;
        end
    end

endmodule

`default_nettype wire

//--- logic/inputController.sv
// User input controller
// Collects key events between frames and applies them at each frame pulse
// Switch 16 selects board switches and buttons instead of the keyboard
`default_nettype none
`include "sandInput_macros.svh"

module inputController (
    input  wire                      iCLK,
    input  wire                      iRESET,
    input  wire                      newFrame,
    input  wire  [17:0]              switches,
    input  wire  [3:0]               keys,
    keyEventIf.consumer              events,
    output sandInput_pkg::particle_t cursorColor,
    output logic [3:0]               cursorSize,
    output logic [9:0]               cursorX,
    output logic [9:0]               cursorY,
    output logic                     cursorDraw,
    output logic [2:0]               faucetSand,
    output logic [2:0]               faucetWater,
    output logic [2:0]               faucetSalt,
    output logic [2:0]               faucetOil,
    output logic                     frameReset,
    output logic                     frameHold,
    output logic                     trollBegin
);

    sandInput_pkg::keyEvent_t ev;
    sandInput_pkg::particle_t chosenColor;
    sandInput_pkg::particle_t letterColor;
    sandInput_pkg::particle_t nextColor;
    logic        byBoard;
    logic        accept;
    logic        plainMake;
    logic        letterHit;
    logic [17:0] prevSwitches;
    logic        pressReset, pressSand, pressWater, pressSalt, pressOil;
    logic        pressMinus, pressPlus, pressTroll, pressPause;
    logic        holdSpace, holdLeft, holdRight, holdUp, holdDown;
    logic        goLeft, goRight, goUp, goDown;
    logic [3:0]  faucetBump;
    logic [3:0]  nextSize;
    logic        nextReset, nextTroll, nextHold, nextDraw;

    // Stall the queue on the frame pulse so no event straddles the update
    assign events.ready = !newFrame;
    assign accept = events.valid && events.ready;
    assign ev = events.keyEvent;
    assign plainMake = accept && !ev.released && !ev.extended;
    assign byBoard = switches[16];

    // Letter keys to particle type
    always_comb begin
        letterHit = 1'b1;
        case (ev.code)
            sandInput_pkg::scA: letterColor = sandInput_pkg::ptBlank;
            sandInput_pkg::scS: letterColor = sandInput_pkg::ptFire;
            sandInput_pkg::scD: letterColor = sandInput_pkg::ptTorch;
            sandInput_pkg::scF: letterColor = sandInput_pkg::ptWater;
            sandInput_pkg::scG: letterColor = sandInput_pkg::ptSand;
            sandInput_pkg::scH: letterColor = sandInput_pkg::ptOil;
            sandInput_pkg::scZ: letterColor = sandInput_pkg::ptSalt;
            sandInput_pkg::scX: letterColor = sandInput_pkg::ptConcrete;
            sandInput_pkg::scC: letterColor = sandInput_pkg::ptWall;
            sandInput_pkg::scV: letterColor = sandInput_pkg::ptPlant;
            sandInput_pkg::scB: letterColor = sandInput_pkg::ptWax;
            sandInput_pkg::scN: letterColor = sandInput_pkg::ptSpout;
            default: begin
                letterHit = 1'b0;
                letterColor = sandInput_pkg::ptBlank;
            end
        endcase
    end

    // Press flags, cleared once the frame has used them
    always_ff @(posedge iCLK) begin
        if (iRESET || newFrame) begin
            {pressReset, pressSand, pressWater, pressSalt, pressOil} <= '0;
            {pressMinus, pressPlus, pressTroll, pressPause} <= '0;
        end else if (plainMake) begin
            case (ev.code)
                sandInput_pkg::scEscape: pressReset <= 1'b1;
                sandInput_pkg::sc1:      pressSand <= 1'b1;
                sandInput_pkg::sc2:      pressWater <= 1'b1;
                sandInput_pkg::sc3:      pressSalt <= 1'b1;
                sandInput_pkg::sc4:      pressOil <= 1'b1;
                sandInput_pkg::scMinus:  pressMinus <= 1'b1;
                sandInput_pkg::scEquals: pressPlus <= 1'b1;
                sandInput_pkg::scT:      pressTroll <= 1'b1;
                sandInput_pkg::scP:      pressPause <= 1'b1;
                default: ;
            endcase
        end
    end

    // Last chosen color persists across frames
    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            chosenColor <= sandInput_pkg::ptBlank;
        end else if (plainMake && letterHit) begin
            chosenColor <= letterColor;
        end
    end

    // Held keys follow make and break events
    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            {holdSpace, holdLeft, holdRight, holdUp, holdDown} <= '0;
        end else if (accept) begin
            if (!ev.extended && ev.code == sandInput_pkg::scSpace) begin
                holdSpace <= !ev.released;
            end
            if (ev.extended) begin
                case (ev.code)
                    sandInput_pkg::scLeft:  holdLeft <= !ev.released;
                    sandInput_pkg::scRight: holdRight <= !ev.released;
                    sandInput_pkg::scUp:    holdUp <= !ev.released;
                    sandInput_pkg::scDown:  holdDown <= !ev.released;
                    default: ;
                endcase
            end
        end
    end

    // Next-frame values for the selected input mode
    always_comb begin
        if (byBoard) begin
            goLeft = keys[0];
            goRight = keys[3];
            goUp = keys[2];
            goDown = keys[1];
            // Rising switch 6 bumps the faucet picked by switches 5:4
            faucetBump = (switches[6] && !prevSwitches[6]) ? (4'b0001 << switches[5:4]) : 4'b0000;
            nextSize = switches[11:8];
            nextColor = sandInput_pkg::particle_t'(switches[3:0]);
            nextDraw = switches[17];
            nextHold = switches[14];
            // Commands fire only on the frame the combination closes
            nextReset = (&switches[16:14]) && !(&prevSwitches[16:14]);
            nextTroll = (&{switches[16:15], switches[13]})
                && !(&{prevSwitches[16:15], prevSwitches[13]});
        end else begin
            goLeft = holdLeft;
            goRight = holdRight;
            goUp = holdUp;
            goDown = holdDown;
            faucetBump = {pressOil, pressSalt, pressWater, pressSand};
            // Plus wins when both size keys arrive in one frame
            if (pressPlus && cursorSize != 4'(`CURSOR_SIZE_MAX)) begin
                nextSize = cursorSize + 4'd1;
            end else if (pressMinus && cursorSize != 4'd0) begin
                nextSize = cursorSize - 4'd1;
            end else begin
                nextSize = cursorSize;
            end
            nextColor = chosenColor;
            nextDraw = holdSpace;
            nextHold = frameHold ^ pressPause;
            nextReset = pressReset;
            nextTroll = pressTroll;
        end
    end

    // Frame update of every output
    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            prevSwitches <= '0;
            cursorColor <= sandInput_pkg::ptBlank;
            cursorSize <= 4'd0;
            cursorX <= 10'(`CURSOR_HOME_X);
            cursorY <= 10'(`CURSOR_HOME_Y);
            cursorDraw <= 1'b0;
            {faucetSand, faucetWater, faucetSalt, faucetOil} <= {4{3'd1}};
            frameReset <= 1'b0;
            frameHold <= 1'b0;
            trollBegin <= 1'b0;
        end else if (newFrame) begin
            prevSwitches <= switches;
            cursorColor <= nextColor;
            cursorSize <= nextSize;
            cursorDraw <= nextDraw;
            frameReset <= nextReset;
            frameHold <= nextHold;
            trollBegin <= nextTroll;
            // Faucet sizes wrap at 8
            faucetSand <= faucetSand + {2'b00, faucetBump[0]};
            faucetWater <= faucetWater + {2'b00, faucetBump[1]};
            faucetSalt <= faucetSalt + {2'b00, faucetBump[2]};
            faucetOil <= faucetOil + {2'b00, faucetBump[3]};
            // One pixel per frame, stop at edges, opposing keys cancel
            if (goLeft && !goRight && cursorX != 10'd0) begin
                cursorX <= cursorX - 10'd1;
            end else if (goRight && !goLeft && cursorX != 10'(`SCREEN_WIDTH - 1)) begin
                cursorX <= cursorX + 10'd1;
            end
            if (goUp && !goDown && cursorY != 10'd0) begin
                cursorY <= cursorY - 10'd1;
            end else if (goDown && !goUp && cursorY != 10'(`SCREEN_HEIGHT - 1)) begin
                cursorY <= cursorY + 10'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sandInputTop.sv
// Sand game input front end
// PS/2 byte decoder, key event queue and per-frame input controller
`default_nettype none
`include "sandInput_macros.svh"

module sandInputTop (
    input  wire                      iCLK,
    input  wire                      iRESET,
    input  wire                      scanValid,
    input  wire  [7:0]               scanByte,
    output logic                     scanReady,
    input  wire                      newFrame,
    input  wire  [17:0]              switches,
    input  wire  [3:0]               keys,
    output sandInput_pkg::particle_t cursorColor,
    output logic [3:0]               cursorSize,
    output logic [9:0]               cursorX,
    output logic [9:0]               cursorY,
    output logic                     cursorDraw,
    output logic [2:0]               faucetSand,
    output logic [2:0]               faucetWater,
    output logic [2:0]               faucetSalt,
    output logic [2:0]               faucetOil,
    output logic                     frameReset,
    output logic                     frameHold,
    output logic                     trollBegin
);

    // Decoder to queue, queue to controller
    keyEventIf decodedIf ();
    keyEventIf queuedIf ();

    ps2EventDecoder u_ps2EventDecoder (
        .iCLK      (iCLK),
        .iRESET    (iRESET),
        .scanValid (scanValid),
        .scanByte  (scanByte),
        .scanReady (scanReady),
        .out       (decodedIf.producer)
    );

    // Absorbs the controller stall on frame pulses
    eventQueue #(
        .payload_t (sandInput_pkg::keyEvent_t),
        .DEPTH     (`EVENT_QUEUE_DEPTH)
    ) u_eventQueue (
        .iCLK   (iCLK),
        .iRESET (iRESET),
        .in     (decodedIf.consumer),
        .out    (queuedIf.producer)
    );

    inputController u_inputController (
        .iCLK        (iCLK),
        .iRESET      (iRESET),
        .newFrame    (newFrame),
        .switches    (switches),
        .keys        (keys),
        .events      (queuedIf.consumer),
        .cursorColor (cursorColor),
        .cursorSize  (cursorSize),
        .cursorX     (cursorX),
        .cursorY     (cursorY),
        .cursorDraw  (cursorDraw),
        .faucetSand  (faucetSand),
        .faucetWater (faucetWater),
        .faucetSalt  (faucetSalt),
        .faucetOil   (faucetOil),
        .frameReset  (frameReset),
        .frameHold   (frameHold),
        .trollBegin  (trollBegin)
    );

endmodule

`default_nettype wire

//--- verification/sandInput_properties.sv
// Sand game input front end properties
// Cursor bounds, frame-only output updates and reset behavior
`default_nettype none
`include "sandInput_macros.svh"

module sandInputProperties (
    input wire       iCLK,
    input wire       iRESET,
    input wire       scanReady,
    input wire       newFrame,
    input wire [3:0] cursorColor,
    input wire [3:0] cursorSize,
    input wire [9:0] cursorX,
    input wire [9:0] cursorY,
    input wire       cursorDraw,
    input wire       frameReset,
    input wire       frameHold,
    input wire       trollBegin
);

    // Cursor never leaves the visible screen
    a_bounds: assert property (@(posedge iCLK) disable iff (iRESET)
        cursorX < `SCREEN_WIDTH && cursorY < `SCREEN_HEIGHT)
        else $error("cursor outside the screen");

    // Outputs move only on the edge that samples the frame pulse
    a_frameOnly: assert property (@(posedge iCLK) disable iff (iRESET)
        !$past(newFrame) |-> $stable({cursorColor, cursorSize, cursorX, cursorY,
            cursorDraw, frameReset, frameHold, trollBegin}))
        else $error("output changed outside a frame update");

    a_readyAfterReset: assert property (@(posedge iCLK) $fell(iRESET) |-> scanReady)
        else $error("scanReady low after reset");

    a_quietInReset: assert property (@(posedge iCLK)
        iRESET && $past(iRESET) |-> !frameReset && !trollBegin && !cursorDraw)
        else $error("command output high during reset");

endmodule

`default_nettype wire

//--- verification/sandInputTb.sv
// Sand game input front end testbench
// Random PS/2 key actions and board settings checked against a frame model
`default_nettype none
`include "sandInput_macros.svh"

module sandInputTb;

    localparam int KB_FRAMES = 40;
    localparam int SIZE_FRAMES = 34;
    localparam int FAUCET_FRAMES = 9;
    localparam int BOARD_FRAMES = 40;
    localparam int SWEEP_FRAMES = 450;
    localparam int EDGE_FRAMES = 6;
    localparam int BURST_FRAMES = 2;
    localparam int TOTAL_FRAMES = KB_FRAMES + SIZE_FRAMES + FAUCET_FRAMES + BOARD_FRAMES
        + SWEEP_FRAMES + EDGE_FRAMES + BURST_FRAMES + 1;
    localparam int CYCLE_LIMIT = 200 * TOTAL_FRAMES;

    logic        iCLK;
    logic        iRESET;
    logic        scanValid;
    logic [7:0]  scanByte;
    logic        scanReady;
    logic        newFrame;
    logic [17:0] switches;
    logic [3:0]  keys;
    sandInput_pkg::particle_t cursorColor;
    logic [3:0]  cursorSize;
    logic [9:0]  cursorX, cursorY;
    logic        cursorDraw, frameReset, frameHold, trollBegin;
    logic [2:0]  faucetSand, faucetWater, faucetSalt, faucetOil;

    // Reference model state
    logic [3:0]  mColor, mSize, mChosen;
    int          mX, mY;
    logic        mDraw, mReset, mHold, mTroll;
    logic [2:0]  mFaucet [4];
    logic        fReset, fMinus, fPlus, fTroll, fPause;
    logic [3:0]  fFaucet;
    logic        hSpace, hLeft, hRight, hUp, hDown;
    logic [17:0] mPrevSw;
    logic [7:0]  keyPool [26];
    logic [7:0]  letters [12];
    int          cycleCount;

    sandInputTop u_sandInputTop (.*);

    bind sandInputTop sandInputProperties u_sandInputProperties (.*);

    always #50 iCLK = !iCLK;

    // Run limit scaled to the number of frames
    always @(posedge iCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycleCount);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task checkValue(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // Key event rules from the controller description
    task applyEvent(input logic ext, input logic rel, input logic [7:0] code);
        if (!ext && !rel) begin
            case (code)
                sandInput_pkg::scEscape: fReset = 1'b1;
                sandInput_pkg::sc1:      fFaucet[0] = 1'b1;
                sandInput_pkg::sc2:      fFaucet[1] = 1'b1;
                sandInput_pkg::sc3:      fFaucet[2] = 1'b1;
                sandInput_pkg::sc4:      fFaucet[3] = 1'b1;
                sandInput_pkg::scMinus:  fMinus = 1'b1;
                sandInput_pkg::scEquals: fPlus = 1'b1;
                sandInput_pkg::scT:      fTroll = 1'b1;
                sandInput_pkg::scP:      fPause = 1'b1;
                default: ;
            endcase
            for (int i = 0; i < 12; i++) begin
                if (letters[i] == code) mChosen = 4'(i);
            end
        end
        if (!ext && code == sandInput_pkg::scSpace) hSpace = !rel;
        if (ext) begin
            case (code)
                sandInput_pkg::scLeft:  hLeft = !rel;
                sandInput_pkg::scRight: hRight = !rel;
                sandInput_pkg::scUp:    hUp = !rel;
                sandInput_pkg::scDown:  hDown = !rel;
                default: ;
            endcase
        end
    endtask

    // Frame update of the model
    task applyFrame();
        logic gl, gr, gu, gd;
        logic [3:0] bump;
        if (switches[16]) begin
            // Buttons 3 to 0 are right, up, down, left
            {gr, gu, gd, gl} = keys;
            bump = 4'b0000;
            if (switches[6] && !mPrevSw[6]) bump[switches[5:4]] = 1'b1;
            mSize = switches[11:8];
            mColor = switches[3:0];
            mDraw = switches[17];
            mHold = switches[14];
            mReset = switches[16] && switches[15] && switches[14]
                && !(mPrevSw[16] && mPrevSw[15] && mPrevSw[14]);
            mTroll = switches[16] && switches[15] && switches[13]
                && !(mPrevSw[16] && mPrevSw[15] && mPrevSw[13]);
        end else begin
            {gl, gr, gu, gd} = {hLeft, hRight, hUp, hDown};
            bump = fFaucet;
            if (fPlus && mSize != 4'd15) mSize = mSize + 4'd1;
            else if (fMinus && mSize != 4'd0) mSize = mSize - 4'd1;
            mColor = mChosen;
            mDraw = hSpace;
            mHold = mHold ^ fPause;
            mReset = fReset;
            mTroll = fTroll;
        end
        for (int i = 0; i < 4; i++) mFaucet[i] = mFaucet[i] + 3'(bump[i]);
        if (gl && !gr && mX > 0) mX = mX - 1;
        else if (gr && !gl && mX < `SCREEN_WIDTH - 1) mX = mX + 1;
        if (gu && !gd && mY > 0) mY = mY - 1;
        else if (gd && !gu && mY < `SCREEN_HEIGHT - 1) mY = mY + 1;
        {fReset, fMinus, fPlus, fTroll, fPause, fFaucet} = '0;
        mPrevSw = switches;
    endtask

    task checkAll();
        checkValue("cursorColor", int'(cursorColor), int'(mColor));
        checkValue("cursorSize", cursorSize, mSize);
        checkValue("cursorX", cursorX, mX);
        checkValue("cursorY", cursorY, mY);
        checkValue("cursorDraw", cursorDraw, mDraw);
        checkValue("faucetSand", faucetSand, mFaucet[0]);
        checkValue("faucetWater", faucetWater, mFaucet[1]);
        checkValue("faucetSalt", faucetSalt, mFaucet[2]);
        checkValue("faucetOil", faucetOil, mFaucet[3]);
        checkValue("frameReset", frameReset, mReset);
        checkValue("frameHold", frameHold, mHold);
        checkValue("trollBegin", trollBegin, mTroll);
    endtask

    // Called just after an edge; returns just after the accepting edge
    task sendByte(input logic [7:0] b);
        scanValid = 1'b1;
        scanByte = b;
        do @(posedge iCLK); while (!scanReady);
        #10;
        scanValid = 1'b0;
    endtask

    task sendKey(input logic ext, input logic rel, input logic [7:0] code, input int gap);
        if (ext) sendByte(`PREFIX_EXTENDED);
        if (rel) sendByte(`PREFIX_BREAK);
        sendByte(code);
        repeat (gap) @(posedge iCLK);
        if (gap > 0) #10;
    endtask

    task pressKey(input logic ext, input logic rel, input logic [7:0] code);
        sendKey(ext, rel, code, $urandom % 4);
        applyEvent(ext, rel, code);
    endtask

    task pulseFrame();
        newFrame = 1'b1;
        @(posedge iCLK);
        #10;
        newFrame = 1'b0;
    endtask

    // Idle, pulse, then compare one cycle after the pulse
    task endFrame();
        repeat (8) @(posedge iCLK);
        #10;
        pulseFrame();
        applyFrame();
        checkAll();
    endtask

    task randomKey();
        logic [7:0] code;
        logic ext;
        code = keyPool[$urandom % 26];
        ext = (code == sandInput_pkg::scLeft) || (code == sandInput_pkg::scRight)
            || (code == sandInput_pkg::scUp) || (code == sandInput_pkg::scDown);
        pressKey(ext, ($urandom % 3) == 0, code);
    endtask

    initial begin
        void'($urandom(32'hd6c6_f7e1));
        keyPool = '{8'h76, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h4E, 8'h55, 8'h2C, 8'h4D,
                    8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34, 8'h33, 8'h1A, 8'h22, 8'h21,
                    8'h2A, 8'h32, 8'h31, 8'h29, 8'h6B, 8'h74, 8'h75, 8'h72};
        // Letter order follows particle type order
        letters = '{8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34, 8'h33,
                    8'h1A, 8'h22, 8'h21, 8'h2A, 8'h32, 8'h31};
        {iCLK, scanValid, scanByte, newFrame, switches, keys} = '0;
        iRESET = 1'b1;
        cycleCount = 0;
        {mColor, mSize, mChosen, mDraw, mReset, mHold, mTroll} = '0;
        mX = `CURSOR_HOME_X;
        mY = `CURSOR_HOME_Y;
        for (int i = 0; i < 4; i++) mFaucet[i] = 3'd1;
        {fReset, fMinus, fPlus, fTroll, fPause, fFaucet} = '0;
        {hSpace, hLeft, hRight, hUp, hDown} = '0;
        mPrevSw = '0;
        repeat (8) @(posedge iCLK);
        #10;
        iRESET = 1'b0;
        checkAll();
        checkValue("scanReady", scanReady, 1);

        // Keyboard mode with random key actions
        repeat (KB_FRAMES) begin
            repeat ($urandom % 5) randomKey();
            endFrame();
        end
        // Size saturation at both ends
        for (int i = 0; i < SIZE_FRAMES; i++) begin
            pressKey(1'b0, 1'b0, (i < SIZE_FRAMES / 2) ? 8'h55 : 8'h4E);
            endFrame();
        end
        // Faucets wrap past 7
        repeat (FAUCET_FRAMES) begin
            for (int k = 0; k < 4; k++) pressKey(1'b0, 1'b0, keyPool[1 + k]);
            endFrame();
        end

        // Board mode with random switches and buttons
        repeat (BOARD_FRAMES) begin
            switches = 18'($urandom) | 18'h10000;
            keys = 4'($urandom);
            endFrame();
        end
        // Hold left and up until both edges saturate
        switches = 18'h10000;
        keys = 4'b0101;
        repeat (SWEEP_FRAMES) endFrame();
        keys = 4'b0000;

        // Keyboard arrows pinned at the top left corner
        switches = '0;
        pressKey(1'b1, 1'b0, sandInput_pkg::scLeft);
        pressKey(1'b1, 1'b0, sandInput_pkg::scUp);
        repeat (EDGE_FRAMES - 1) endFrame();
        pressKey(1'b1, 1'b1, sandInput_pkg::scLeft);
        pressKey(1'b1, 1'b1, sandInput_pkg::scUp);
        pressKey(1'b0, 1'b1, sandInput_pkg::scSpace);
        endFrame();

        // Burst straddling a frame pulse, only the first key lands before it
        fork
            begin
                sendKey(1'b0, 1'b0, 8'h16, 0);
                applyEvent(1'b0, 1'b0, 8'h16);
                sendKey(1'b0, 1'b1, 8'h16, 0);
                sendKey(1'b0, 1'b0, 8'h1E, 0);
                sendKey(1'b0, 1'b0, 8'h26, 0);
                sendKey(1'b0, 1'b0, 8'h34, 0);
                sendKey(1'b0, 1'b0, 8'h25, 0);
            end
            begin
                // Pulse while the break event waits at the queue head
                repeat (4) @(posedge iCLK);
                #10;
                pulseFrame();
                applyFrame();
                checkAll();
            end
        join
        applyEvent(1'b0, 1'b1, 8'h16);
        applyEvent(1'b0, 1'b0, 8'h1E);
        applyEvent(1'b0, 1'b0, 8'h26);
        applyEvent(1'b0, 1'b0, 8'h34);
        applyEvent(1'b0, 1'b0, 8'h25);
        endFrame();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/sandInput_pkg.sv
logic/keyEventIf.sv
logic/ps2EventDecoder.sv
logic/eventQueue.sv
logic/inputController.sv
logic/sandInputTop.sv
verification/sandInput_properties.sv
verification/sandInputTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= sandInputTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
